//--- build.f
hw/arb_pkg.sv
hw/arb_owner.sv
hw/mem_issue.sv
hw/line_mem.sv
hw/cache_arbiter_top.sv
testbench/cache_arbiter_assert.sv
testbench/tb_cache_arbiter.sv

//--- Makefile
# Verilator flow for the cache arbiter testbench

VERILATOR ?= verilator
TOP       ?= tb_cache_arbiter
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_TEXT ?= Simulation finished: PASS

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(SIM_BIN): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

//--- testbench/arbiter_testdata.txt
# test port op(0 write, 1 read, 2 release cyc) adr sel data group
# read data is the expected line, group > 0 starts both ports together
2 0 0 010 ffff 00112233445566778899aabbccddeeff 0
2 0 0 010 00ff a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5 0
2 0 1 010 0000 0011223344556677a5a5a5a5a5a5a5a5 0
2 0 2 000 0000 00000000000000000000000000000000 0
2 1 0 020 ffff 0123456789abcdef0123456789abcdef 0
2 1 0 020 f00f deadbeef000000000000000012345678 0
2 1 1 020 0000 deadbeef89abcdef0123456712345678 0
2 1 2 000 0000 00000000000000000000000000000000 0
3 0 1 010 0000 0011223344556677a5a5a5a5a5a5a5a5 1
3 0 2 000 0000 00000000000000000000000000000000 1
3 1 1 020 0000 deadbeef89abcdef0123456712345678 1
3 1 2 000 0000 00000000000000000000000000000000 1
4 1 0 030 ffff cafef00dcafef00dcafef00dcafef00d 0
4 1 0 031 ffff 11111111111111111111111111111111 2
4 1 1 030 0000 cafef00dcafef00dcafef00dcafef00d 2
4 1 2 000 0000 00000000000000000000000000000000 2
4 0 1 020 0000 deadbeef89abcdef0123456712345678 2
4 0 2 000 0000 00000000000000000000000000000000 2
5 0 0 040 ffff 40404040404040404040404040404040 3
5 0 0 040 000f 000000000000000000000000ffffffff 3
5 0 1 040 0000 404040404040404040404040ffffffff 3
5 0 2 000 0000 00000000000000000000000000000000 3
5 1 0 050 ffff 50505050505050505050505050505050 3
5 1 0 050 ff00 abababababababab0000000000000000 3
5 1 1 050 0000 abababababababab5050505050505050 3
5 1 2 000 0000 00000000000000000000000000000000 3
5 1 1 040 0000 404040404040404040404040ffffffff 0
5 1 2 000 0000 00000000000000000000000000000000 0
5 0 1 050 0000 abababababababab5050505050505050 0
5 0 2 000 0000 00000000000000000000000000000000 0
5 0 1 031 0000 11111111111111111111111111111111 4
5 0 2 000 0000 00000000000000000000000000000000 4
5 1 1 010 0000 0011223344556677a5a5a5a5a5a5a5a5 4
5 1 2 000 0000 00000000000000000000000000000000 4

//--- testbench/tb_cache_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module tb_cache_arbiter;

    localparam int MEM_LATENCY = 3;
    localparam int TIMEOUT     = 200;     // cycles per wait
    localparam int MAX_CMDS    = 64;
    localparam int OP_WRITE    = 0;
    localparam int OP_READ     = 1;
    localparam int OP_RELEASE  = 2;

    logic                          clk;
    logic                          i_reset;
    logic                          p0_cyc, p0_stb, p0_we, p0_ack, p0_rty;
    logic                          p1_cyc, p1_stb, p1_we, p1_ack, p1_rty;
    logic [arb_pkg::SEL_BITS-1:0]  p0_sel, p1_sel;
    logic [arb_pkg::ADDR_BITS-1:0] p0_adr, p1_adr;
    logic [arb_pkg::LINE_BITS-1:0] p0_dat, p1_dat, p0_rdat, p1_rdat;

    // command table loaded from the data file
    int                            cmd_test  [MAX_CMDS];
    int                            cmd_port  [MAX_CMDS];
    int                            cmd_op    [MAX_CMDS];
    int                            cmd_group [MAX_CMDS];
    logic [arb_pkg::ADDR_BITS-1:0] cmd_adr   [MAX_CMDS];
    logic [arb_pkg::SEL_BITS-1:0]  cmd_sel   [MAX_CMDS];
    logic [arb_pkg::LINE_BITS-1:0] cmd_dat   [MAX_CMDS];

    int  n_cmds;
    int  errors;
    int  tests_done;
    int  cmds_done;
    time rise_time [2];     // when each port last raised cyc
    int  rel_count [2];     // cyc releases per port

    cache_arbiter_top #(
        .MEM_LATENCY (MEM_LATENCY)
    ) u_dut (
        .clk      (clk),
        .i_reset  (i_reset),
        .i_p0_cyc (p0_cyc),
        .i_p0_stb (p0_stb),
        .i_p0_we  (p0_we),
        .i_p0_sel (p0_sel),
        .i_p0_adr (p0_adr),
        .i_p0_dat (p0_dat),
        .o_p0_ack (p0_ack),
        .o_p0_dat (p0_rdat),
        .o_p0_rty (p0_rty),
        .i_p1_cyc (p1_cyc),
        .i_p1_stb (p1_stb),
        .i_p1_we  (p1_we),
        .i_p1_sel (p1_sel),
        .i_p1_adr (p1_adr),
        .i_p1_dat (p1_dat),
        .o_p1_ack (p1_ack),
        .o_p1_dat (p1_rdat),
        .o_p1_rty (p1_rty)
    );

    bind cache_arbiter_top cache_arbiter_assert u_assert (
        .clk      (clk),
        .i_reset  (i_reset),
        .i_p0_cyc (i_p0_cyc),
        .i_p1_cyc (i_p1_cyc),
        .i_p0_ack (o_p0_ack),
        .i_p1_ack (o_p1_ack),
        .i_p0_rty (o_p0_rty),
        .i_p1_rty (o_p1_rty)
    );

    always #2 clk = ~clk;

    function automatic logic cyc_of(input int port);
        return (port == 0) ? p0_cyc : p1_cyc;
    endfunction

    function automatic logic ack_of(input int port);
        return (port == 0) ? p0_ack : p1_ack;
    endfunction

    function automatic logic rty_of(input int port);
        return (port == 0) ? p0_rty : p1_rty;
    endfunction

    function automatic logic [arb_pkg::LINE_BITS-1:0] rdat_of(input int port);
        return (port == 0) ? p0_rdat : p1_rdat;
    endfunction

    task automatic load_commands();
        int    fd;
        int    n;
        int    t, p, o, g;
        string line;
        logic [arb_pkg::ADDR_BITS-1:0] a;
        logic [arb_pkg::SEL_BITS-1:0]  s;
        logic [arb_pkg::LINE_BITS-1:0] d;
        fd = $fopen("testbench/arbiter_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open the test data file");
            errors++;
        end else begin
            while (!$feof(fd) && n_cmds < MAX_CMDS) begin
                n = 0;
                if ($fgets(line, fd) != 0) begin
                    n = $sscanf(line, "%d %d %d %h %h %h %d", t, p, o, a, s, d, g);
                end
                if (n == 7) begin               // comment lines give no match
                    cmd_test[n_cmds]  = t;
                    cmd_port[n_cmds]  = p;
                    cmd_op[n_cmds]    = o;
                    cmd_adr[n_cmds]   = a;
                    cmd_sel[n_cmds]   = s;
                    cmd_dat[n_cmds]   = d;
                    cmd_group[n_cmds] = g;
                    n_cmds++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic idle_gap();
        int n;
        n = $urandom % 4;
        repeat (n) @(posedge clk);
    endtask

    task automatic set_port(input int port, input logic cyc, input logic stb, input int idx);
        if (port == 0) begin
            p0_cyc <= cyc;
            p0_stb <= stb;
            p0_we  <= (cmd_op[idx] == OP_WRITE);
            p0_sel <= cmd_sel[idx];
            p0_adr <= cmd_adr[idx];
            p0_dat <= cmd_dat[idx];
        end else begin
            p1_cyc <= cyc;
            p1_stb <= stb;
            p1_we  <= (cmd_op[idx] == OP_WRITE);
            p1_sel <= cmd_sel[idx];
            p1_adr <= cmd_adr[idx];
            p1_dat <= cmd_dat[idx];
        end
    endtask

    // one strobe, held until ack, then dropped
    task automatic run_strobe(input int idx);
        int   port, other, waited, rel_snap, exp_lat;
        logic held, blocked, seen_rty, acked;
        logic [arb_pkg::LINE_BITS-1:0] got;
        port     = cmd_port[idx];
        other    = 1 - port;
        held     = cyc_of(port);
        blocked  = 1'b0;
        seen_rty = 1'b0;
        acked    = 1'b0;
        rel_snap = rel_count[other];
        got      = '0;
        waited   = 0;
        if (!held) begin
            rise_time[port] = $time;
        end
        set_port(port, 1'b1, 1'b1, idx);
        while (!acked && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
            if (waited == 1 && !held) begin     // other port owns the bus or wins the tie?
                blocked  = cyc_of(other) && (rise_time[other] < rise_time[port]
                           || (rise_time[other] == rise_time[port] && other == 0));
                rel_snap = rel_count[other];
            end
            if (rty_of(port)) begin
                seen_rty = 1'b1;
            end
            if (ack_of(port)) begin
                acked = 1'b1;
                got   = rdat_of(port);
            end
        end
        if (!acked) begin
            $display("port %0d got no ack within %0d cycles", port, TIMEOUT);
            errors++;
        end else begin
            if (blocked && rel_count[other] == rel_snap) begin
                $display("port %0d was acked while port %0d still held the bus", port, other);
                errors++;
            end
            if (blocked && !seen_rty) begin
                $display("port %0d waited for the bus without seeing rty", port);
                errors++;
            end
            // grant takes one more cycle when cyc rises from idle
            exp_lat = MEM_LATENCY + (held ? 3 : 4);
            if (!seen_rty && waited != exp_lat) begin
                $display("ERR ack_latency_p%0d exp %0h got %0h", port, exp_lat, waited);
                errors++;
            end
            if (cmd_op[idx] == OP_READ && got !== cmd_dat[idx]) begin
                $display("ERR o_p%0d_dat exp %h got %h", port, cmd_dat[idx], got);
                errors++;
            end
        end
        @(posedge clk);
        set_port(port, 1'b1, 1'b0, idx);
        @(negedge clk);
        if (ack_of(port)) begin
            $display("port %0d saw a second ack for one strobe", port);
            errors++;
        end
    endtask

    task automatic run_cmd(input int idx);
        int port;
        port = cmd_port[idx];
        @(posedge clk);
        if (cmd_op[idx] == OP_RELEASE) begin
            set_port(port, 1'b0, 1'b0, idx);
            rel_count[port]++;
        end else begin
            run_strobe(idx);
        end
        cmds_done++;
    endtask

    // commands of one port inside a group, in file order
    task automatic run_port_list(input int port, input int first, input int last);
        logic started;
        started = 1'b0;
        for (int k = first; k < last; k++) begin
            if (cmd_port[k] == port) begin
                if (started) begin
                    idle_gap();
                end
                started = 1'b1;
                run_cmd(k);
            end
        end
    endtask

    task automatic check_reset_state();
        for (int k = 0; k < 4; k++) begin
            @(negedge clk);
            if (p0_ack !== 1'b0) begin
                $display("ERR o_p0_ack exp 0 got %h", p0_ack);
                errors++;
            end
            if (p1_ack !== 1'b0) begin
                $display("ERR o_p1_ack exp 0 got %h", p1_ack);
                errors++;
            end
            if (p0_rty !== 1'b0) begin
                $display("ERR o_p0_rty exp 0 got %h", p0_rty);
                errors++;
            end
            if (p1_rty !== 1'b0) begin
                $display("ERR o_p1_rty exp 0 got %h", p1_rty);
                errors++;
            end
        end
        tests_done++;
        $display("test 1 finished: reset state, %0s", (errors == 0) ? "ok" : "errors");
    endtask

    task automatic run_all();
        int i, j, start, cur_test, err_start;
        i = 0;
        while (i < n_cmds) begin
            cur_test  = cmd_test[i];
            err_start = errors;
            start     = i;
            while (i < n_cmds && cmd_test[i] == cur_test) begin
                idle_gap();
                if (cmd_group[i] == 0) begin
                    run_cmd(i);
                    i++;
                end else begin
                    j = i;
                    while (j < n_cmds && cmd_test[j] == cur_test
                           && cmd_group[j] == cmd_group[i]) begin
                        j++;
                    end
                    fork
                        run_port_list(0, i, j);
                        run_port_list(1, i, j);
                    join
                    i = j;
                end
            end
            tests_done++;
            $display("test %0d finished: %0d commands, %0s", cur_test, i - start,
                     (errors == err_start) ? "ok" : "errors");
        end
    endtask

    initial begin
        void'($urandom(32'hd88d));
        clk        = 1'b0;
        i_reset    = 1'b1;
        p0_cyc     = 1'b0;
        p0_stb     = 1'b0;
        p0_we      = 1'b0;
        p0_sel     = '0;
        p0_adr     = '0;
        p0_dat     = '0;
        p1_cyc     = 1'b0;
        p1_stb     = 1'b0;
        p1_we      = 1'b0;
        p1_sel     = '0;
        p1_adr     = '0;
        p1_dat     = '0;
        n_cmds     = 0;
        errors     = 0;
        tests_done = 0;
        cmds_done  = 0;
        rise_time  = '{0, 0};
        rel_count  = '{0, 0};
        load_commands();
        repeat (8) @(posedge clk);
        i_reset <= 1'b0;
        check_reset_state();
        run_all();
        $display("tests %0d, commands %0d, errors %0d", tests_done, cmds_done, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule : tb_cache_arbiter

`default_nettype wire

//--- testbench/cache_arbiter_assert.sv
`timescale 1ns/10ps
`default_nettype none

module cache_arbiter_assert (
    input wire logic clk,
    input wire logic i_reset,
    input wire logic i_p0_cyc,
    input wire logic i_p1_cyc,
    input wire logic i_p0_ack,
    input wire logic i_p1_ack,
    input wire logic i_p0_rty,
    input wire logic i_p1_rty
);

    // only one transaction in flight, so one ack at a time
    a_single_ack: assert property (@(posedge clk) disable iff (i_reset)
        !(i_p0_ack && i_p1_ack))
        else $error("ack raised on both ports in one cycle");

    a_p0_ack_rty: assert property (@(posedge clk) disable iff (i_reset)
        !(i_p0_ack && i_p0_rty))
        else $error("port 0 ack and rty high together");

    a_p1_ack_rty: assert property (@(posedge clk) disable iff (i_reset)
        !(i_p1_ack && i_p1_rty))
        else $error("port 1 ack and rty high together");

    a_p0_ack_cyc: assert property (@(posedge clk) disable iff (i_reset)
        i_p0_ack |-> i_p0_cyc)
        else $error("port 0 ack without cyc");

    a_p1_ack_cyc: assert property (@(posedge clk) disable iff (i_reset)
        i_p1_ack |-> i_p1_cyc)
        else $error("port 1 ack without cyc");

    // responses quiet right after reset
    a_reset_quiet: assert property (@(posedge clk)
        $past(i_reset) |-> !(i_p0_ack || i_p1_ack || i_p0_rty || i_p1_rty))
        else $error("ack or rty high after reset");

endmodule : cache_arbiter_assert

`default_nettype wire

//--- hw/cache_arbiter_top.sv
`timescale 1ns/10ps
`default_nettype none

module cache_arbiter_top #(
    parameter int MEM_LATENCY = 3
) (
    input  wire logic                          clk,
    input  wire logic                          i_reset,

    // instruction cache port
    input  wire logic                          i_p0_cyc,
    input  wire logic                          i_p0_stb,
    input  wire logic                          i_p0_we,
    input  wire logic [arb_pkg::SEL_BITS-1:0]  i_p0_sel,
    input  wire logic [arb_pkg::ADDR_BITS-1:0] i_p0_adr,
    input  wire logic [arb_pkg::LINE_BITS-1:0] i_p0_dat,
    output logic                               o_p0_ack,
    output logic      [arb_pkg::LINE_BITS-1:0] o_p0_dat,
    output logic                               o_p0_rty,

    // data cache port
    input  wire logic                          i_p1_cyc,
    input  wire logic                          i_p1_stb,
    input  wire logic                          i_p1_we,
    input  wire logic [arb_pkg::SEL_BITS-1:0]  i_p1_sel,
    input  wire logic [arb_pkg::ADDR_BITS-1:0] i_p1_adr,
    input  wire logic [arb_pkg::LINE_BITS-1:0] i_p1_dat,
    output logic                               o_p1_ack,
    output logic      [arb_pkg::LINE_BITS-1:0] o_p1_dat,
    output logic                               o_p1_rty
);

    // owner request into the issue stage
    logic                          req_stb;
    logic                          req_we;
    logic [arb_pkg::SEL_BITS-1:0]  req_sel;
    logic [arb_pkg::ADDR_BITS-1:0] req_adr;
    logic [arb_pkg::LINE_BITS-1:0] req_dat;

    // issue stage back to the owner stage
    logic                          busy;
    logic                          resp_ack;
    logic [arb_pkg::LINE_BITS-1:0] resp_dat;

    // issue stage to line memory
    logic                          mem_stb;
    logic                          mem_we;
    logic [arb_pkg::SEL_BITS-1:0]  mem_sel;
    logic [arb_pkg::ADDR_BITS-1:0] mem_adr;
    logic [arb_pkg::LINE_BITS-1:0] mem_wdat;
    logic                          mem_ack;
    logic [arb_pkg::LINE_BITS-1:0] mem_rdat;

    arb_owner u_owner (
        .clk        (clk),
        .i_reset    (i_reset),
        .i_p0_cyc   (i_p0_cyc),
        .i_p0_stb   (i_p0_stb),
        .i_p0_we    (i_p0_we),
        .i_p0_sel   (i_p0_sel),
        .i_p0_adr   (i_p0_adr),
        .i_p0_dat   (i_p0_dat),
        .i_p1_cyc   (i_p1_cyc),
        .i_p1_stb   (i_p1_stb),
        .i_p1_we    (i_p1_we),
        .i_p1_sel   (i_p1_sel),
        .i_p1_adr   (i_p1_adr),
        .i_p1_dat   (i_p1_dat),
        .i_busy     (busy),
        .i_resp_ack (resp_ack),
        .i_resp_dat (resp_dat),
        .o_req_stb  (req_stb),
        .o_req_we   (req_we),
        .o_req_sel  (req_sel),
        .o_req_adr  (req_adr),
        .o_req_dat  (req_dat),
        .o_p0_ack   (o_p0_ack),
        .o_p0_dat   (o_p0_dat),
        .o_p0_rty   (o_p0_rty),
        .o_p1_ack   (o_p1_ack),
        .o_p1_dat   (o_p1_dat),
        .o_p1_rty   (o_p1_rty)
    );

    mem_issue u_issue (
        .clk        (clk),
        .i_reset    (i_reset),
        .i_req_stb  (req_stb),
        .i_req_we   (req_we),
        .i_req_sel  (req_sel),
        .i_req_adr  (req_adr),
        .i_req_dat  (req_dat),
        .i_mem_ack  (mem_ack),
        .i_mem_dat  (mem_rdat),
        .o_busy     (busy),
        .o_resp_ack (resp_ack),
        .o_resp_dat (resp_dat),
        .o_mem_stb  (mem_stb),
        .o_mem_we   (mem_we),
        .o_mem_sel  (mem_sel),
        .o_mem_adr  (mem_adr),
        .o_mem_dat  (mem_wdat)
    );

    line_mem #(
        .MEM_LATENCY (MEM_LATENCY)
    ) u_mem (
        .clk     (clk),
        .i_reset (i_reset),
        .i_stb   (mem_stb),
        .i_we    (mem_we),
        .i_sel   (mem_sel),
        .i_adr   (mem_adr),
        .i_dat   (mem_wdat),
        .o_ack   (mem_ack),
        .o_dat   (mem_rdat)
    );

endmodule : cache_arbiter_top

`default_nettype wire

//--- hw/line_mem.sv
`timescale 1ns/10ps
`default_nettype none

module line_mem #(
    parameter int MEM_LATENCY = 3     // cycles from sampled stb to ack, 1 or more
) (
    input  wire logic                          clk,
    input  wire logic                          i_reset,

    input  wire logic                          i_stb,
    input  wire logic                          i_we,
    input  wire logic [arb_pkg::SEL_BITS-1:0]  i_sel,
    input  wire logic [arb_pkg::ADDR_BITS-1:0] i_adr,
    input  wire logic [arb_pkg::LINE_BITS-1:0] i_dat,

    output logic                               o_ack,
    output logic      [arb_pkg::LINE_BITS-1:0] o_dat
);

    localparam int DEPTH     = 2 ** arb_pkg::ADDR_BITS;
    localparam int LANE_BITS = arb_pkg::LINE_BITS / arb_pkg::SEL_BITS;
    localparam int CNT_BITS  = $clog2(MEM_LATENCY + 1);

    logic [arb_pkg::LINE_BITS-1:0] mem [DEPTH];

    logic [CNT_BITS-1:0] cnt;       // cycles left until ack
    logic                start;     // new access sampled
    logic                ack_set;   // ack goes high next cycle

    assign start = i_stb & (cnt == '0);

    // a latency of one acks straight off the strobe
    assign ack_set = (MEM_LATENCY == 1) ? start : (cnt == CNT_BITS'(1));

    always_ff @(posedge clk) begin
        if (i_reset) begin
            cnt   <= '0;
            o_ack <= 1'b0;
        end else begin
            o_ack <= ack_set;
            if (start && MEM_LATENCY > 1) begin
                cnt <= CNT_BITS'(MEM_LATENCY - 1);
            end else if (cnt != '0) begin
                cnt <= cnt - CNT_BITS'(1);
            end
        end
    end

    // byte-lane write at the sampling edge
    always_ff @(posedge clk) begin
        if (start && i_we) begin
            for (int i = 0; i < arb_pkg::SEL_BITS; i++) begin
                if (i_sel[i]) begin
                    mem[i_adr][i*LANE_BITS +: LANE_BITS] <= i_dat[i*LANE_BITS +: LANE_BITS];
                end
            end
        end
    end

    // read line comes out together with ack, adr is held by the issuer
    always_ff @(posedge clk) begin
        if (ack_set && !i_we) begin
            o_dat <= mem[i_adr];
        end
    end

endmodule : line_mem

`default_nettype wire

//--- hw/mem_issue.sv
`timescale 1ns/10ps
`default_nettype none

module mem_issue (
    input  wire logic                          clk,
    input  wire logic                          i_reset,

    // request from the ownership stage
    input  wire logic                          i_req_stb,
    input  wire logic                          i_req_we,
    input  wire logic [arb_pkg::SEL_BITS-1:0]  i_req_sel,
    input  wire logic [arb_pkg::ADDR_BITS-1:0] i_req_adr,
    input  wire logic [arb_pkg::LINE_BITS-1:0] i_req_dat,

    // answer from the line memory
    input  wire logic                          i_mem_ack,
    input  wire logic [arb_pkg::LINE_BITS-1:0] i_mem_dat,

    output logic                               o_busy,
    output logic                               o_resp_ack,
    output logic      [arb_pkg::LINE_BITS-1:0] o_resp_dat,

    // memory side, fields stay put for the whole access
    output logic                               o_mem_stb,
    output logic                               o_mem_we,
    output logic      [arb_pkg::SEL_BITS-1:0]  o_mem_sel,
    output logic      [arb_pkg::ADDR_BITS-1:0] o_mem_adr,
    output logic      [arb_pkg::LINE_BITS-1:0] o_mem_dat
);

    typedef enum logic [1:0] {
        S_IDLE    = 2'd0,
        S_FLUSH   = 2'd1,   // write the line out
        S_FETCH   = 2'd2,   // read the line in
        S_RESPOND = 2'd3
    } state_e;

    state_e state;
    state_e next_state;

    logic accept;           // strobe taken this cycle
    logic fetch_done;       // read line arrives

    logic [arb_pkg::ADDR_BITS-1:0] adr_q;
    logic [arb_pkg::LINE_BITS-1:0] wr_dat_q;
    logic [arb_pkg::LINE_BITS-1:0] rd_dat_q;
    logic [arb_pkg::SEL_BITS-1:0]  sel_q;
    logic                          we_q;
    logic                          mem_stb_q;

    assign accept     = (state == S_IDLE) & i_req_stb;
    assign fetch_done = (state == S_FETCH) & i_mem_ack;

    always_comb begin
        next_state = state;
        case (state)
            S_IDLE: begin
                if (i_req_stb) begin
                    next_state = i_req_we ? S_FLUSH : S_FETCH;
                end
            end
            S_FLUSH: begin
                if (i_mem_ack) begin                           // write landed
                    next_state = S_RESPOND;
                end
            end
            S_FETCH: begin
                if (i_mem_ack) begin                           // line captured below
                    next_state = S_RESPOND;
                end
            end
            // one ack pulse, then back without looking at stb
            S_RESPOND: next_state = S_IDLE;
            default:   next_state = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state     <= S_IDLE;
            mem_stb_q <= 1'b0;
        end else begin
            state     <= next_state;
            mem_stb_q <= accept;                               // first cycle of flush/fetch
        end
    end

    // address and data registers
    always_ff @(posedge clk) begin
        if (accept) begin
            we_q     <= i_req_we;
            sel_q    <= i_req_sel;
            adr_q    <= i_req_adr;
            wr_dat_q <= i_req_dat;
        end
        if (fetch_done) begin
            rd_dat_q <= i_mem_dat;
        end
    end

    assign o_busy     = (state != S_IDLE);
    assign o_resp_ack = (state == S_RESPOND);
    assign o_resp_dat = rd_dat_q;

    assign o_mem_stb = mem_stb_q;
    assign o_mem_we  = we_q;
    assign o_mem_sel = sel_q;
    assign o_mem_adr = adr_q;
    assign o_mem_dat = wr_dat_q;

endmodule : mem_issue

`default_nettype wire

//--- hw/arb_owner.sv
`timescale 1ns/10ps
`default_nettype none

module arb_owner (
    input  wire logic                          clk,
    input  wire logic                          i_reset,

    // port 0, instruction cache
    input  wire logic                          i_p0_cyc,
    input  wire logic                          i_p0_stb,
    input  wire logic                          i_p0_we,
    input  wire logic [arb_pkg::SEL_BITS-1:0]  i_p0_sel,
    input  wire logic [arb_pkg::ADDR_BITS-1:0] i_p0_adr,
    input  wire logic [arb_pkg::LINE_BITS-1:0] i_p0_dat,

    // port 1, data cache
    input  wire logic                          i_p1_cyc,
    input  wire logic                          i_p1_stb,
    input  wire logic                          i_p1_we,
    input  wire logic [arb_pkg::SEL_BITS-1:0]  i_p1_sel,
    input  wire logic [arb_pkg::ADDR_BITS-1:0] i_p1_adr,
    input  wire logic [arb_pkg::LINE_BITS-1:0] i_p1_dat,

    // response from the issue stage
    input  wire logic                          i_busy,
    input  wire logic                          i_resp_ack,
    input  wire logic [arb_pkg::LINE_BITS-1:0] i_resp_dat,

    // request of the current owner
    output logic                               o_req_stb,
    output logic                               o_req_we,
    output logic      [arb_pkg::SEL_BITS-1:0]  o_req_sel,
    output logic      [arb_pkg::ADDR_BITS-1:0] o_req_adr,
    output logic      [arb_pkg::LINE_BITS-1:0] o_req_dat,

    output logic                               o_p0_ack,
    output logic      [arb_pkg::LINE_BITS-1:0] o_p0_dat,
    output logic                               o_p0_rty,
    output logic                               o_p1_ack,
    output logic      [arb_pkg::LINE_BITS-1:0] o_p1_dat,
    output logic                               o_p1_rty
);

    arb_pkg::owner_e owner;
    arb_pkg::owner_e next_owner;

    // port 0 wins from idle, the owner keeps the bus while cyc or busy is up
    always_comb begin
        next_owner = owner;
        case (owner)
            arb_pkg::OWN_NONE: begin
                if (i_p0_cyc) begin
                    next_owner = arb_pkg::OWN_P0;
                end else if (i_p1_cyc) begin
                    next_owner = arb_pkg::OWN_P1;
                end
            end
            arb_pkg::OWN_P0: begin
                if (!i_p0_cyc && !i_busy) begin                // p0 lets go
                    next_owner = i_p1_cyc ? arb_pkg::OWN_P1 : arb_pkg::OWN_NONE;
                end
            end
            arb_pkg::OWN_P1: begin
                if (!i_p1_cyc && !i_busy) begin                // p1 lets go
                    next_owner = i_p0_cyc ? arb_pkg::OWN_P0 : arb_pkg::OWN_NONE;
                end
            end
            default: next_owner = arb_pkg::OWN_NONE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            owner <= arb_pkg::OWN_NONE;
        end else begin
            owner <= next_owner;
        end
    end

    // request mux on the registered owner
    always_comb begin
        o_req_stb = 1'b0;
        o_req_we  = 1'b0;
        o_req_sel = '0;
        o_req_adr = '0;
        o_req_dat = '0;
        case (owner)
            arb_pkg::OWN_P0: begin
                o_req_stb = i_p0_cyc & i_p0_stb;
                o_req_we  = i_p0_we;
                o_req_sel = i_p0_sel;
                o_req_adr = i_p0_adr;
                o_req_dat = i_p0_dat;
            end
            arb_pkg::OWN_P1: begin
                o_req_stb = i_p1_cyc & i_p1_stb;
                o_req_we  = i_p1_we;
                o_req_sel = i_p1_sel;
                o_req_adr = i_p1_adr;
                o_req_dat = i_p1_dat;
            end
            default: ;                                         // no owner, no request
        endcase
    end

    // response goes to the owner, rty to a port left waiting
    assign o_p0_ack = (owner == arb_pkg::OWN_P0) & i_resp_ack;
    assign o_p1_ack = (owner == arb_pkg::OWN_P1) & i_resp_ack;
    assign o_p0_dat = (owner == arb_pkg::OWN_P0) ? i_resp_dat : '0;
    assign o_p1_dat = (owner == arb_pkg::OWN_P1) ? i_resp_dat : '0;
    assign o_p0_rty = (owner == arb_pkg::OWN_P1) & i_p0_cyc;
    assign o_p1_rty = (owner == arb_pkg::OWN_P0) & i_p1_cyc;

endmodule : arb_owner

`default_nettype wire

//--- hw/arb_pkg.sv
`default_nettype none

package arb_pkg;

    // one cache line travels as a single word
    localparam int LINE_BITS = 128;

    // one enable bit per byte of the line
    localparam int SEL_BITS = LINE_BITS / 8;

    // line address, 4096 lines in the backing store
    localparam int ADDR_BITS = 12;

    // who holds the shared memory path
    // port 0 is the icache, port 1 the dcache
    typedef enum logic [1:0] {
        OWN_NONE = 2'd0,    // bus free
        OWN_P0   = 2'd1,    // icache owns
        OWN_P1   = 2'd2     // dcache owns
    } owner_e;

endpackage : arb_pkg

`default_nettype wire
